// File: sim/rotate_stimulus.txt
// each record is three hex words: type address data
// type 1 key row, 2 rotation value, 3 coefficient, 4 run (data 1 adds a start while busy), 5 expected, f end
// key row 0 doubles a coefficient, row 1 adds its balanced digits to it
1 0 1000010000100001   1 1 0001000100010001
1 2 0000000000000000   1 3 0000000000000000
1 4 0000000000000000   1 5 0000000000000000
1 6 0000000000000000
// accumulator bank 0, chunks at and around 8 push carries through all digits
3 0 0000  3 1 0001  3 2 0007  3 3 0008
3 4 000f  3 5 0078  3 6 0777  3 7 0888
3 8 7fff  3 9 8000  3 a ffff  3 b 1234
3 c 9abc  3 d 0808  3 e 7777  3 f fff8
// run 1, every rotation value zero, bank 0 reads back unchanged
2 0 0  2 1 0  2 2 0  2 3 0
2 4 0  2 5 0  2 6 0  2 7 0
4 0 0
5 0 0000  5 1 0001  5 2 0007  5 3 0008
5 4 000f  5 5 0078  5 6 0777  5 7 0888
5 8 7fff  5 9 8000  5 a ffff  5 b 1234
5 c 9abc  5 d 0808  5 e 7777  5 f fff8
// run 2, one pass with value 2 at entry 3, result lands in bank 1
2 0 0  2 1 0  2 2 0  2 3 2
2 4 0  2 5 0  2 6 0  2 7 0
4 0 0
5 0 0000  5 1 0002  5 2 000e  5 3 0001
5 4 000f  5 5 0069  5 6 078c  5 7 0873
5 8 7ff6  5 9 7ff8  5 a fffe  5 b 123e
5 c 9aa9  5 d 07fa  5 e 7793  5 f fff0
// run 3, value 2 then value 1 on the last entry, extra start while busy, result in bank 0
2 0 0  2 1 2  2 2 0  2 3 0
2 4 0  2 5 0  2 6 0  2 7 1
4 0 1
5 0 0000  5 1 0004  5 2 001c  5 3 0002
5 4 001e  5 5 00d2  5 6 0f18  5 7 10e6
5 8 ffec  5 9 fff0  5 a fffc  5 b 247c
5 c 3552  5 d 0ff4  5 e ef26  5 f ffe0
f 0 0

// File: blind_rotate.f
rtl/rotate_pkg.sv
rtl/coef_stream_if.sv
rtl/dual_port_ram.sv
rtl/rotate_control.sv
rtl/digit_decomposer.sv
rtl/coef_fifo.sv
rtl/key_mac.sv
rtl/blind_rotate_top.sv
sim/blind_rotate_properties.sv
sim/tb_blind_rotate.sv

// File: sim/tb_blind_rotate.sv
`timescale 1ns/10ps
/*
 * Testbench for the blind rotation accumulator.
 * Loads key rows, rotation values and coefficients from the stimulus file,
 * runs rotations and compares the read back result bank with expected values.
 */
module tb_blind_rotate import rotate_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 8;
    localparam int STIM_WORDS   = 600;                  // three words per record
    localparam int RUN_CYCLES   = NUM_A * (3 + RING_SIZE * (NUM_DIGITS + 2) + 4);
    localparam int QUIET_CYCLES = NUM_A * 3 + 3;        // longest run with no pass at all
    localparam int MAX_GAP      = 4;
    localparam logic [63:0] OP_KEY    = 64'h1;
    localparam logic [63:0] OP_ROT    = 64'h2;
    localparam logic [63:0] OP_COEF   = 64'h3;
    localparam logic [63:0] OP_RUN    = 64'h4;
    localparam logic [63:0] OP_EXPECT = 64'h5;
    localparam logic [63:0] OP_END    = 64'hf;

    logic                  clk;
    logic                  reset;
    logic                  acc_we;
    logic [RING_DEPTH-1:0] acc_waddr;
    coef_t                 acc_wdata;
    logic                  a_we;
    logic [A_DEPTH-1:0]    a_waddr;
    logic [A_W-1:0]        a_wdata;
    logic                  key_we;
    logic [A_W-1:0]        key_waddr;
    key_row_t              key_wdata;
    logic                  start;
    logic                  busy;
    logic                  done;
    logic [RING_DEPTH-1:0] rd_addr;
    coef_t                 rd_data;

    logic [63:0]    stim [STIM_WORDS];
    logic [A_W-1:0] rot_shadow [NUM_A];  // rotation list as the DUT holds it
    int             value_errors;
    int             other_errors;
    int             cycle_count;
    int             cycle_limit;
    logic [31:0]    lcg_state;
    int             rec;
    logic           finished;

    blind_rotate_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .acc_we    (acc_we),
        .acc_waddr (acc_waddr),
        .acc_wdata (acc_wdata),
        .a_we      (a_we),
        .a_waddr   (a_waddr),
        .a_wdata   (a_wdata),
        .key_we    (key_we),
        .key_waddr (key_waddr),
        .key_wdata (key_wdata),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("no done from the DUT within the limit of %0d cycles", cycle_limit);
            report_totals();
            $display("test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // loads and readbacks take one cycle each, runs take the worst case bound
    function automatic int cycle_budget();
        int runs;
        int others;
        runs   = 0;
        others = 0;
        for (int r = 0; r < STIM_WORDS / 3; r++) begin
            if (stim[3 * r] == OP_END) begin
                break;
            end else if (stim[3 * r] == OP_RUN) begin
                runs++;
            end else begin
                others++;
            end
        end
        return RESET_CYCLES + 2 * others + runs * (RUN_CYCLES + QUIET_CYCLES + MAX_GAP + 2) + 16;
    endfunction

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic report_totals();
        $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errors, other_errors, dut_i.props_i.failures);
    endtask

    task automatic compare_coef(input string name, input coef_t expected, input coef_t actual);
        if (actual !== expected) begin
            $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR time=%0t signal=%s expected=%b actual=%b", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("at %0t: %s", $time, what);
        other_errors++;
    endtask

    task automatic load_word(input logic [63:0] op, input logic [63:0] addr,
                             input logic [63:0] data);
        if (op == OP_KEY) begin
            key_we    = 1'b1;
            key_waddr = addr[A_W-1:0];
            key_wdata = data;
        end else if (op == OP_ROT) begin
            a_we    = 1'b1;
            a_waddr = addr[A_DEPTH-1:0];
            a_wdata = data[A_W-1:0];
            rot_shadow[addr[A_DEPTH-1:0]] = data[A_W-1:0];
        end else begin
            acc_we    = 1'b1;
            acc_waddr = addr[RING_DEPTH-1:0];
            acc_wdata = data[DATA_W-1:0];
        end
        step();
        key_we = 1'b0;
        a_we   = 1'b0;
        acc_we = 1'b0;
    endtask

    task automatic idle_gap();
        int gap;
        lcg_state = lcg_next(lcg_state);
        gap       = 1 + int'(lcg_state[18:16]) % MAX_GAP;
        repeat (gap) step();
    endtask

    // one start, optionally a second start while busy that must be ignored
    task automatic run_rotation(input logic poke_busy);
        int waited;
        int done_seen;
        int nonzero;
        nonzero = 0;
        for (int i = 0; i < NUM_A; i++) begin
            if (rot_shadow[i] != '0) nonzero++;
        end
        start = 1'b1;
        step();
        start  = 1'b0;
        waited = 0;
        compare_bit("busy", 1'b1, busy);
        while (done !== 1'b1) begin
            start = poke_busy && (waited == 2);
            step();
            waited++;
        end
        start     = 1'b0;
        done_seen = 1;
        compare_bit("busy", 1'b0, busy); // busy drops in the done cycle
        if (nonzero == 0 && waited > QUIET_CYCLES) begin
            note_failure($sformatf("run with no pass took %0d cycles to done", waited));
        end
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            step();
            if (done === 1'b1) done_seen++;
        end
        if (done_seen != 1) begin
            note_failure($sformatf("%0d done pulses for one accepted start", done_seen));
        end
        compare_bit("busy", 1'b0, busy);
    endtask

    task automatic check_coef(input logic [63:0] addr, input logic [63:0] data);
        rd_addr = addr[RING_DEPTH-1:0];
        step();                          // read port answers one cycle later
        compare_coef($sformatf("rd_data[%0d]", addr[RING_DEPTH-1:0]),
                     data[DATA_W-1:0], rd_data);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        acc_we       = 1'b0;
        acc_waddr    = '0;
        acc_wdata    = '0;
        a_we         = 1'b0;
        a_waddr      = '0;
        a_wdata      = '0;
        key_we       = 1'b0;
        key_waddr    = '0;
        key_wdata    = '0;
        start        = 1'b0;
        rd_addr      = '0;
        value_errors = 0;
        other_errors = 0;
        cycle_count  = 0;
        lcg_state    = 32'h9b60;
        finished     = 1'b0;
        rec          = 0;
        for (int i = 0; i < NUM_A; i++) rot_shadow[i] = '0;
        $readmemh("sim/rotate_stimulus.txt", stim);
        cycle_limit = cycle_budget();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        compare_bit("busy", 1'b0, busy);
        compare_bit("done", 1'b0, done);
        while (!finished) begin
            case (stim[3 * rec])
                OP_KEY, OP_ROT, OP_COEF: load_word(stim[3 * rec], stim[3 * rec + 1],
                                                   stim[3 * rec + 2]);
                OP_RUN: begin
                    idle_gap();
                    run_rotation(stim[3 * rec + 2][0]);
                end
                OP_EXPECT: check_coef(stim[3 * rec + 1], stim[3 * rec + 2]);
                OP_END: finished = 1'b1;
                default: begin
                    note_failure($sformatf("stimulus record %0d has unknown type %h",
                                           rec, stim[3 * rec]));
                    finished = 1'b1;
                end
            endcase
            rec++;
            if (!finished && rec >= STIM_WORDS / 3) begin
                note_failure("stimulus file has no end record");
                finished = 1'b1;
            end
        end
        step();
        report_totals();
        if (value_errors == 0 && other_errors == 0 && dut_i.props_i.failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sim/blind_rotate_properties.sv
`timescale 1ns/10ps
/*
 * Protocol checks for the blind rotation top level.
 * Watches the start/done status pair and the internal stream handshakes.
 */
module blind_rotate_properties (
    input logic clk,
    input logic reset,
    input logic busy,
    input logic done,
    input logic acc_we,
    input logic dec_valid,
    input logic dec_ready,
    input logic mac_valid,
    input logic mac_ready
);

    int unsigned failures = 0; // assertion failures seen so far

    done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            failures++;
        end

    busy_with_done: assert property (@(posedge clk) disable iff (reset) $fell(busy) |-> done)
        else begin
            $error("busy fell without a done pulse");
            failures++;
        end

    // a beat offered and not taken stays on the link
    dec_hold: assert property (@(posedge clk) disable iff (reset)
        dec_valid && !dec_ready |=> dec_valid)
        else begin
            $error("decomposer dropped valid before ready");
            failures++;
        end

    mac_hold: assert property (@(posedge clk) disable iff (reset)
        mac_valid && !mac_ready |=> mac_valid)
        else begin
            $error("FIFO dropped valid before ready");
            failures++;
        end

    no_host_write: assert property (@(posedge clk) disable iff (reset) busy |-> !acc_we)
        else begin
            $error("host accumulator write while busy");
            failures++;
        end

endmodule

bind blind_rotate_top blind_rotate_properties props_i (
    .clk       (clk),
    .reset     (reset),
    .busy      (busy),
    .done      (done),
    .acc_we    (acc_we),
    .dec_valid (dec_stream.valid),
    .dec_ready (dec_stream.ready),
    .mac_valid (mac_stream.valid),
    .mac_ready (mac_stream.ready)
);

// File: rtl/blind_rotate_top.sv
`timescale 1ns/10ps
/*
 * Blind rotation accumulator, top level.
 * Joins the memories, the sequencer and the decompose, buffer and
 * multiply-accumulate stream.
 */
module blind_rotate_top import rotate_pkg::*; #(
    parameter int RING_DEPTH = rotate_pkg::RING_DEPTH,
    parameter int A_DEPTH    = rotate_pkg::A_DEPTH,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  acc_we,
    input  logic [RING_DEPTH-1:0] acc_waddr,
    input  coef_t                 acc_wdata,
    input  logic                  a_we,
    input  logic [A_DEPTH-1:0]    a_waddr,
    input  logic [A_W-1:0]        a_wdata,
    input  logic                  key_we,
    input  logic [A_W-1:0]        key_waddr,
    input  key_row_t              key_wdata,
    input  logic                  start,
    output logic                  busy,
    output logic                  done,
    input  logic [RING_DEPTH-1:0] rd_addr,
    output coef_t                 rd_data
);

    logic [A_DEPTH-1:0]    a_raddr;
    logic [A_W-1:0]        a_value;
    logic [A_W-1:0]        key_row_addr;
    key_row_t              key_row;
    logic                  pass_start;
    logic                  pass_done;
    logic [RING_DEPTH-1:0] dec_index;
    logic                  mac_we;
    logic [RING_DEPTH-1:0] mac_index;
    coef_t                 mac_data;
    logic                  ram_we;
    logic [RING_DEPTH:0]   ram_waddr;
    coef_t                 ram_wdata;
    logic [RING_DEPTH:0]   ram_raddr;

    coef_stream_if #(.RING_DEPTH(RING_DEPTH)) dec_stream ();
    coef_stream_if #(.RING_DEPTH(RING_DEPTH)) mac_stream ();

    ////////////////////////////////////////////////////////////
    // memories
    ////////////////////////////////////////////////////////////

    // two banks, the top address bit picks the bank
    dual_port_ram #(.WIDTH(DATA_W), .ADDR_W(RING_DEPTH + 1)) acc_ram_i (
        .clk        (clk),
        .write_en   (ram_we),
        .write_addr (ram_waddr),
        .write_data (ram_wdata),
        .read_addr  (ram_raddr),
        .read_data  (rd_data)
    );

    dual_port_ram #(.WIDTH(A_W), .ADDR_W(A_DEPTH)) a_ram_i (
        .clk        (clk),
        .write_en   (a_we),
        .write_addr (a_waddr),
        .write_data (a_wdata),
        .read_addr  (a_raddr),
        .read_data  (a_value)
    );

    dual_port_ram #(.WIDTH($bits(key_row_t)), .ADDR_W(A_W)) key_ram_i (
        .clk        (clk),
        .write_en   (key_we),
        .write_addr (key_waddr),
        .write_data (key_wdata),
        .read_addr  (key_row_addr),
        .read_data  (key_row)
    );

    ////////////////////////////////////////////////////////////
    // sequencer and coefficient stream
    ////////////////////////////////////////////////////////////

    rotate_control #(.RING_DEPTH(RING_DEPTH), .A_DEPTH(A_DEPTH)) rotate_control_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .busy         (busy),
        .done         (done),
        .a_addr       (a_raddr),
        .a_value      (a_value),
        .key_row_addr (key_row_addr),
        .pass_start   (pass_start),
        .pass_done    (pass_done),
        .dec_index    (dec_index),
        .mac_we       (mac_we),
        .mac_index    (mac_index),
        .mac_data     (mac_data),
        .host_we      (acc_we),
        .host_addr    (acc_waddr),
        .host_data    (acc_wdata),
        .rd_addr      (rd_addr),
        .acc_we       (ram_we),
        .acc_waddr    (ram_waddr),
        .acc_wdata    (ram_wdata),
        .acc_raddr    (ram_raddr)
    );

    digit_decomposer #(.RING_DEPTH(RING_DEPTH)) digit_decomposer_i (
        .clk        (clk),
        .reset      (reset),
        .pass_start (pass_start),
        .read_index (dec_index),
        .read_data  (rd_data),
        .out        (dec_stream.source)
    );

    coef_fifo #(.RING_DEPTH(RING_DEPTH), .FIFO_DEPTH(FIFO_DEPTH)) coef_fifo_i (
        .clk   (clk),
        .reset (reset),
        .in    (dec_stream.sink),
        .out   (mac_stream.source)
    );

    key_mac #(.RING_DEPTH(RING_DEPTH)) key_mac_i (
        .clk         (clk),
        .reset       (reset),
        .key_row     (key_row),
        .in          (mac_stream.sink),
        .write_en    (mac_we),
        .write_index (mac_index),
        .write_data  (mac_data),
        .pass_done   (pass_done)
    );

endmodule

// File: rtl/key_mac.sv
`timescale 1ns/10ps
/*
 * Key multiply-accumulate unit, stream consumer.
 * Adds each digit times its key word to the old coefficient, one digit
 * per cycle on a shared multiplier, and writes the result back.
 */
module key_mac import rotate_pkg::*; #(
    parameter int RING_DEPTH = rotate_pkg::RING_DEPTH
) (
    input  logic                  clk,
    input  logic                  reset,
    input  key_row_t              key_row,
    coef_stream_if.sink           in,
    output logic                  write_en,
    output logic [RING_DEPTH-1:0] write_index,
    output coef_t                 write_data,
    output logic                  pass_done
);

    localparam int DSEL_W = (NUM_DIGITS > 1) ? $clog2(NUM_DIGITS) : 1;
    localparam logic [DSEL_W-1:0] LAST_DIGIT = DSEL_W'(NUM_DIGITS - 1);

    logic                       working;    // digits of the held beat still to process
    logic [DSEL_W-1:0]          digit_sel;
    logic                       accept;
    digit_vec_t                 digits_q;
    coef_t                      acc;
    digit_t                     digit_cur;
    logic signed [DATA_W-1:0]   digit_ext;
    coef_t                      key_word;
    logic signed [2*DATA_W-1:0] product;

    assign accept    = in.valid && in.ready;
    assign in.ready  = !working;

    assign digit_cur = digits_q[digit_sel*DIGIT_W +: DIGIT_W];
    assign digit_ext = {{(DATA_W-DIGIT_W){digit_cur[DIGIT_W-1]}}, digit_cur};
    assign key_word  = key_row[digit_sel*DATA_W +: DATA_W];
    assign product   = digit_ext * $signed(key_word); // only the low DATA_W bits are kept

    assign write_data = acc;
    assign pass_done  = write_en && (write_index == '1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            working   <= 1'b0;
            digit_sel <= '0;
            write_en  <= 1'b0;
        end else begin
            write_en <= working && (digit_sel == LAST_DIGIT); // one cycle after the last digit
            if (accept) begin
                working   <= 1'b1;
                digit_sel <= '0;
            end else if (working) begin
                if (digit_sel == LAST_DIGIT) begin
                    working   <= 1'b0;
                    digit_sel <= '0;
                end else begin
                    digit_sel <= digit_sel + 1'b1;
                end
            end
        end
    end

    // the write cycle may already accept the next beat, acc reloads after it
    always_ff @(posedge clk) begin
        if (accept) begin
            acc         <= in.value;
            digits_q    <= in.digits;
            write_index <= in.index;
        end else if (working) begin
            acc <= acc + coef_t'(product[DATA_W-1:0]);
        end
    end

endmodule

// File: rtl/coef_fifo.sv
`timescale 1ns/10ps
/*
 * Coefficient FIFO.
 * Circular buffer between the decomposer and the multiply-accumulate unit.
 */
module coef_fifo import rotate_pkg::*; #(
    parameter int RING_DEPTH = rotate_pkg::RING_DEPTH,
    parameter int FIFO_DEPTH = 4
) (
    input  logic          clk,
    input  logic          reset,
    coef_stream_if.sink   in,
    coef_stream_if.source out
);

    localparam int PTR_W   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int ENTRY_W = RING_DEPTH + $bits(coef_t) + $bits(digit_vec_t);

    logic [ENTRY_W-1:0] store [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               push;
    logic               pop;

    function automatic logic [PTR_W-1:0] bump(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in.ready  = (count != (PTR_W+1)'(FIFO_DEPTH));
    assign out.valid = (count != '0); // head is visible straight from the store
    assign {out.index, out.value, out.digits} = store[rd_ptr];

    assign push = in.valid && in.ready;
    assign pop  = out.valid && out.ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= bump(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither leaves the level alone
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            store[wr_ptr] <= {in.index, in.value, in.digits};
        end
    end

endmodule

// File: rtl/digit_decomposer.sv
`timescale 1ns/10ps
/*
 * Digit decomposer, stream producer.
 * Reads one bank coefficient by coefficient and splits each word into
 * balanced signed digits.
 */
module digit_decomposer import rotate_pkg::*; #(
    parameter int RING_DEPTH = rotate_pkg::RING_DEPTH
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pass_start,
    output logic [RING_DEPTH-1:0] read_index,
    input  coef_t                 read_data,
    coef_stream_if.source         out
);

    localparam logic [RING_DEPTH-1:0] LAST_INDEX = '1;

    logic                  active;      // reads still to issue in this pass
    logic [RING_DEPTH-1:0] next_index;
    logic                  s1_valid;    // read_data holds the word for s1_index
    logic [RING_DEPTH-1:0] s1_index;
    logic                  advance;
    logic                  issue;

    // least significant chunk first, a chunk of 8 or more borrows from the next one
    function automatic digit_vec_t split(coef_t word);
        digit_vec_t       digits;
        logic [DIGIT_W:0] sum;
        logic             carry;
        carry = 1'b0;
        for (int k = 0; k < NUM_DIGITS; k++) begin
            sum   = {1'b0, word[k*DIGIT_W +: DIGIT_W]} + {{DIGIT_W{1'b0}}, carry};
            digits[k*DIGIT_W +: DIGIT_W] = sum[DIGIT_W-1:0];
            carry = (sum[DIGIT_W:DIGIT_W-1] != 2'b00);
        end
        return digits; // final carry falls off, wrap mod 2^DATA_W
    endfunction

    assign advance = !out.valid || out.ready;
    assign issue   = active && advance;

    // under back-pressure keep reading the word that is waiting
    assign read_index = advance ? next_index : s1_index;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active     <= 1'b0;
            next_index <= '0;
            s1_valid   <= 1'b0;
            s1_index   <= '0;
            out.valid  <= 1'b0;
        end else begin
            if (pass_start) begin
                active     <= 1'b1;
                next_index <= '0;
            end else if (issue) begin
                next_index <= next_index + 1'b1;
                if (next_index == LAST_INDEX) begin
                    active <= 1'b0;
                end
            end
            if (advance) begin
                s1_valid  <= issue;
                s1_index  <= next_index;
                out.valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out.index  <= s1_index;
            out.value  <= read_data;
            out.digits <= split(read_data);
        end
    end

endmodule

// File: rtl/rotate_control.sv
`timescale 1ns/10ps
/*
 * Rotation sequencer.
 * Walks the rotation list, skips zero entries, launches one pass per
 * nonzero value, flips the accumulator bank and muxes the memory ports.
 */
module rotate_control import rotate_pkg::*; #(
    parameter int RING_DEPTH = rotate_pkg::RING_DEPTH,
    parameter int A_DEPTH    = rotate_pkg::A_DEPTH
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    output logic                  busy,
    output logic                  done,
    output logic [A_DEPTH-1:0]    a_addr,
    input  logic [A_W-1:0]        a_value,
    output logic [A_W-1:0]        key_row_addr,
    output logic                  pass_start,
    input  logic                  pass_done,
    input  logic [RING_DEPTH-1:0] dec_index,
    input  logic                  mac_we,
    input  logic [RING_DEPTH-1:0] mac_index,
    input  coef_t                 mac_data,
    input  logic                  host_we,
    input  logic [RING_DEPTH-1:0] host_addr,
    input  coef_t                 host_data,
    input  logic [RING_DEPTH-1:0] rd_addr,
    output logic                  acc_we,
    output logic [RING_DEPTH:0]   acc_waddr,
    output coef_t                 acc_wdata,
    output logic [RING_DEPTH:0]   acc_raddr
);

    localparam logic [A_DEPTH-1:0] LAST_ENTRY = '1;

    rot_state_t         state;
    logic [A_DEPTH-1:0] ptr;         // current rotation list entry
    logic               bank;        // bank holding the live accumulator
    logic               idle;
    logic               last_entry;
    logic               a_nonzero;

    assign idle       = (state == IDLE);
    assign last_entry = (ptr == LAST_ENTRY);
    assign a_nonzero  = (a_value != '0);

    ////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= IDLE;
            ptr          <= '0;
            bank         <= 1'b0;
            key_row_addr <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= FETCH_A;
                        ptr   <= '0;
                        bank  <= 1'b0; // host always loads bank 0
                    end
                end
                FETCH_A: begin
                    state <= CHECK_A; // list memory answers one cycle later
                end
                CHECK_A: begin
                    if (a_nonzero) begin
                        key_row_addr <= a_value - 1'b1; // row 0 serves value 1
                        state        <= PASS;
                    end else if (last_entry) begin
                        state <= FINISH;
                    end else begin
                        ptr   <= ptr + 1'b1;
                        state <= FETCH_A;
                    end
                end
                PASS: begin
                    if (pass_done) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    bank <= ~bank; // the freshly written bank becomes live
                    if (last_entry) begin
                        state <= FINISH;
                    end else begin
                        ptr   <= ptr + 1'b1;
                        state <= FETCH_A;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign a_addr     = ptr;
    assign pass_start = (state == CHECK_A) && a_nonzero;
    assign done       = (state == FINISH);
    assign busy       = !idle && (state != FINISH); // drops together with done

    ////////////////////////////////////////////////////////////
    // accumulator port muxing
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (idle) begin
            acc_we    = host_we;
            acc_waddr = {1'b0, host_addr};
            acc_wdata = host_data;
        end else begin
            acc_we    = mac_we;
            acc_waddr = {~bank, mac_index}; // results go to the other bank
            acc_wdata = mac_data;
        end
    end

    // idle reads show the result bank to the host
    assign acc_raddr = {bank, idle ? rd_addr : dec_index};

endmodule

// File: rtl/dual_port_ram.sv
`timescale 1ns/10ps
/*
 * Simple dual port memory.
 * One synchronous write port and one registered read port.
 */
module dual_port_ram #(
    parameter int WIDTH  = 16,
    parameter int ADDR_W = 4
) (
    input  logic              clk,
    input  logic              write_en,
    input  logic [ADDR_W-1:0] write_addr,
    input  logic [WIDTH-1:0]  write_data,
    input  logic [ADDR_W-1:0] read_addr,
    output logic [WIDTH-1:0]  read_data
);

    logic [WIDTH-1:0] mem [1 << ADDR_W];

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
        read_data <= mem[read_addr]; // old data on a same address collision
    end

endmodule

// File: rtl/coef_stream_if.sv
`timescale 1ns/10ps
/*
 * Coefficient stream link.
 * Carries one decomposed coefficient per valid/ready beat.
 */
interface coef_stream_if import rotate_pkg::*; #(
    parameter int RING_DEPTH = rotate_pkg::RING_DEPTH
);
    logic                  valid;
    logic                  ready;
    logic [RING_DEPTH-1:0] index;   // coefficient position in the ring
    coef_t                 value;   // coefficient before the pass
    digit_vec_t            digits;  // balanced signed digits of value

    // the source holds valid and payload steady until ready is seen
    modport source (
        output valid,
        output index,
        output value,
        output digits,
        input  ready
    );

    modport sink (
        input  valid,
        input  index,
        input  value,
        input  digits,
        output ready
    );

endinterface

// File: rtl/rotate_pkg.sv
/*
 * Blind rotation shared definitions.
 * Widths, ring and list sizes, controller states and the digit,
 * coefficient and key row types used across the accumulator design.
 */
package rotate_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    parameter int DATA_W     = 16;              // coefficient width, arithmetic is mod 2^DATA_W
    parameter int DIGIT_W    = 4;               // width of one balanced signed digit
    parameter int NUM_DIGITS = 4;               // digits per coefficient, NUM_DIGITS*DIGIT_W == DATA_W
    parameter int RING_DEPTH = 4;
    parameter int RING_SIZE  = 1 << RING_DEPTH; // coefficients per polynomial
    parameter int A_W        = 3;               // rotation value width, zero means skip
    parameter int A_DEPTH    = 3;
    parameter int NUM_A      = 1 << A_DEPTH;    // rotation list length

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    typedef logic signed [DIGIT_W-1:0]       digit_t;
    typedef logic [NUM_DIGITS*DIGIT_W-1:0]   digit_vec_t;  // digit k sits at bits k*DIGIT_W
    typedef logic [DATA_W-1:0]               coef_t;
    typedef logic [NUM_DIGITS*DATA_W-1:0]    key_row_t;    // key word k sits at bits k*DATA_W

    // sequencer states, one fetch and one check cycle per list entry
    typedef enum logic [2:0] {
        IDLE,
        FETCH_A,
        CHECK_A,
        PASS,
        DRAIN,
        FINISH
    } rot_state_t;

endpackage
